/* list.f */
+incdir+.
w65Pkg.sv
w65IntCtrl.sv
w65StatusReg.sv
w65BusUnit.sv
w65Sequencer.sv
w65Core.sv
tbW65Core.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary -f list.f --top-module tbW65Core -Mdir obj_dir -o simW65

run: build
	./obj_dir/simW65 | tee sim.log
	grep -q "^Test OK$$" sim.log

lint:
	verilator --lint-only --timing -f list.f --top-module tbW65Core

clean:
	rm -rf obj_dir sim.log

/* tbW65Core.sv */
`include "w65_config.svh"

module tbW65Core;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int accessLimit = 50;
  localparam int runBudget   = 40 + 80 + 80 + 2 * 100 + 150 + 900;  // Cycles summed over the tests

  logic           CLK;
  logic           RST_N;
  logic           ce;
  logic           rdyIn;
  logic           nmiN;
  logic           irqN;
  w65Pkg::dataT   dataIn;
  w65Pkg::addrT   addr;
  logic           vpa;
  logic           vda;
  logic           vpb;
  logic           rdyOut;
  w65Pkg::statusT status;

  w65Pkg::dataT   mem [0:65535];
  w65Pkg::dataT   prog[$];
  w65Pkg::addrT   trace[$];
  w65Pkg::addrT   plainAddrs[$];
  w65Pkg::addrT   pcExp;
  w65Pkg::statusT statusExp;
  int             errors;
  int             checks;

  assign dataIn = mem[addr];  // Asynchronous read

  w65Core i_w65Core
  (
    .CLK    (CLK),
    .RST_N  (RST_N),
    .ce     (ce),
    .rdyIn  (rdyIn),
    .nmiN   (nmiN),
    .irqN   (irqN),
    .dataIn (dataIn),
    .addr   (addr),
    .vpa    (vpa),
    .vda    (vda),
    .vpb    (vpb),
    .rdyOut (rdyOut),
    .status (status)
  );

  initial
  begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  task automatic checkAddr(input string name, input w65Pkg::addrT got, input w65Pkg::addrT exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkStatus(input string name, input w65Pkg::statusT got,
                             input w65Pkg::statusT exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Reference model of the status register
  function automatic w65Pkg::statusT nextStatus(input w65Pkg::statusT s, input w65Pkg::dataT op,
                                                input w65Pkg::dataT arg);
    w65Pkg::statusT n;
    n = s;
    case (op)
      8'h18: n[0] = 1'b0;  // CLC
      8'h38: n[0] = 1'b1;  // SEC
      8'h58: n[2] = 1'b0;  // CLI
      8'h78: n[2] = 1'b1;  // SEI
      8'hB8: n[6] = 1'b0;  // CLV
      8'hD8: n[3] = 1'b0;  // CLD
      8'hF8: n[3] = 1'b1;  // SED
      `W65_OP_REP:
      begin
        n[7:0] = s[7:0] & ~arg;
        if (s[8])
          n[5:4] = 2'b11;
      end
      `W65_OP_SEP: n[7:0] = s[7:0] | arg;
      `W65_OP_XCE:
      begin
        n[8] = s[0];
        n[0] = s[8];
        if (s[0])
          n[5:4] = 2'b11;
      end
      default: n = s;
    endcase
    return n;
  endfunction

  task automatic toDrivePoint;
    @(posedge CLK);
    #2;
  endtask

  task automatic setVector(input w65Pkg::addrT vec, input w65Pkg::addrT target);
    mem[vec] = target[7:0];
    mem[vec + 16'd1] = target[15:8];
  endtask

  task automatic loadMemory;
    w65Pkg::addrT a;
    int           i;
    for (i = 0; i < 65536; i++)
    begin
      a = w65Pkg::addrT'(i);
      mem[a] = a[15:8] ^ a[7:0] ^ 8'h5A;
    end
    for (i = 32'h8000; i < 32'h9400; i++)
      mem[w65Pkg::addrT'(i)] = 8'hEA;  // NOP code and handler area
    setVector(`W65_VEC_RESET, 16'h8000);
    setVector(`W65_VEC_NMI_NATIVE, 16'h9000);
    setVector(`W65_VEC_NMI_EMU, 16'h9100);
    setVector(`W65_VEC_IRQ_NATIVE, 16'h9200);
    setVector(`W65_VEC_IRQ_EMU, 16'h9300);
    for (i = 0; i < prog.size(); i++)
      mem[16'h8000 + w65Pkg::addrT'(i)] = prog[i];
  endtask

  task automatic applyReset;
    toDrivePoint();
    RST_N = 1'b0;
    ce    = 1'b1;
    rdyIn = 1'b1;
    nmiN  = 1'b1;
    irqN  = 1'b1;
    repeat (4) @(posedge CLK);
    #2;
    RST_N = 1'b1;
  endtask

  task automatic nextAccess(output int cycles);
    cycles = 0;
    do
    begin
      @(negedge CLK);
      cycles++;
    end
    while (!(rdyOut && (vpa || vda)) && cycles < accessLimit);
    if (!(rdyOut && (vpa || vda)))
    begin
      errors++;
      $display("No bus access seen within %0d cycles", accessLimit);
    end
  endtask

  task automatic expectAccess(input string what, input w65Pkg::addrT expAddr, input logic expVpa,
                              input logic expVda, input logic expVpb, input int expCycles);
    int cycles;
    nextAccess(cycles);
    if (expCycles > 0 && cycles != expCycles)
    begin
      errors++;
      $display("ERROR %s cycles: got %h expected %h", what, cycles, expCycles);
    end
    checkAddr({what, " addr"}, addr, expAddr);
    checkBit({what, " vpa"}, vpa, expVpa);
    checkBit({what, " vda"}, vda, expVda);
    checkBit({what, " vpb"}, vpb, expVpb);
  endtask

  task automatic resetEntry;
    applyReset();
    expectAccess("reset vector low", `W65_VEC_RESET, 1'b0, 1'b1, 1'b0, 0);
    expectAccess("reset vector high", `W65_VEC_RESET + 16'd1, 1'b0, 1'b1, 1'b0, 1);
    expectAccess("reset fetch", 16'h8000, 1'b1, 1'b1, 1'b1, 1);
    pcExp     = 16'h8000;
    statusExp = `W65_STATUS_RESET;
    checkStatus("status after reset", status, statusExp);
  endtask

  // Runs the instruction at pcExp up to the next opcode fetch
  task automatic stepInstr(input w65Pkg::dataT op, input w65Pkg::dataT arg);
    if (op == `W65_OP_REP || op == `W65_OP_SEP)
    begin
      expectAccess("operand", pcExp + 16'd1, 1'b1, 1'b0, 1'b1, 1);
      pcExp = pcExp + 16'd1;
    end
    pcExp = pcExp + 16'd1;
    expectAccess("fetch", pcExp, 1'b1, 1'b1, 1'b1, 2);
    statusExp = nextStatus(statusExp, op, arg);
    checkStatus("status", status, statusExp);
  endtask

  task automatic enterVector(input w65Pkg::addrT vec, input w65Pkg::addrT handler);
    int cycles;
    int n;
    n = 0;
    do
    begin
      nextAccess(cycles);
      n++;
    end
    while (vpb && n < 20);
    if (vpb)
    begin
      errors++;
      $display("No vector fetch seen after the interrupt request");
    end
    checkAddr("vector low addr", addr, vec);
    checkBit("vector low vpa", vpa, 1'b0);
    checkBit("vector low vda", vda, 1'b1);
    toDrivePoint();
    nmiN = 1'b1;
    irqN = 1'b1;
    expectAccess("vector high", vec + 16'd1, 1'b0, 1'b1, 1'b0, 1);
    expectAccess("handler fetch", handler, 1'b1, 1'b1, 1'b1, 1);
    pcExp = handler;
  endtask

  task automatic waitRdyLow(input string what);
    int n;
    n = 0;
    do
    begin
      @(negedge CLK);
      n++;
    end
    while (rdyOut && n < 10);
    if (rdyOut)
    begin
      errors++;
      $display("rdyOut did not drop after %s", what);
    end
  endtask

  task automatic testResetEntry;
    prog.delete();
    loadMemory();
    resetEntry();
    stepInstr(8'hEA, 8'h00);
    stepInstr(8'hEA, 8'h00);
  endtask

  task automatic testEmuFlags;
    w65Pkg::dataT ops[7];
    ops = '{8'h18, 8'h38, 8'hF8, 8'hD8, 8'h78, 8'h58, 8'hB8};
    prog = {`W65_OP_SEP, 8'h41, `W65_OP_REP, 8'h04};  // Each flag starts opposite its first op
    foreach (ops[k])
      prog.push_back(ops[k]);
    prog = {prog, `W65_OP_SEP, 8'hFF, `W65_OP_REP, 8'hFF};
    loadMemory();
    resetEntry();
    stepInstr(`W65_OP_SEP, 8'h41);
    stepInstr(`W65_OP_REP, 8'h04);
    foreach (ops[k])
      stepInstr(ops[k], 8'h00);
    stepInstr(`W65_OP_SEP, 8'hFF);
    stepInstr(`W65_OP_REP, 8'hFF);
  endtask

  task automatic testNativeMode;
    prog = {8'h38, 8'h18, `W65_OP_XCE, `W65_OP_REP, 8'h30, 8'h18, 8'h38, `W65_OP_XCE};
    loadMemory();
    resetEntry();
    stepInstr(8'h38, 8'h00);
    stepInstr(8'h18, 8'h00);
    stepInstr(`W65_OP_XCE, 8'h00);
    stepInstr(`W65_OP_REP, 8'h30);
    stepInstr(8'h18, 8'h00);
    stepInstr(8'h38, 8'h00);
    stepInstr(`W65_OP_XCE, 8'h00);
  endtask

  task automatic testNmi(input logic native);
    int cycles;
    prog.delete();
    if (native)
      prog = {8'h18, `W65_OP_XCE};
    loadMemory();
    resetEntry();
    if (native)
    begin
      stepInstr(8'h18, 8'h00);
      stepInstr(`W65_OP_XCE, 8'h00);
    end
    stepInstr(8'hEA, 8'h00);
    toDrivePoint();
    nmiN = 1'b0;
    enterVector(native ? `W65_VEC_NMI_NATIVE : `W65_VEC_NMI_EMU, native ? 16'h9000 : 16'h9100);
    repeat (20)
    begin
      nextAccess(cycles);
      checkBit("vpb after NMI", vpb, 1'b1);  // One edge gives one entry
    end
  endtask

  task automatic testIrqWai;
    prog = {8'hEA, 8'hEA, 8'hEA, 8'h58, `W65_OP_WAI};
    loadMemory();
    mem[16'h9301] = `W65_OP_STP;
    resetEntry();
    toDrivePoint();
    irqN = 1'b0;  // Masked by I
    repeat (3)
      stepInstr(8'hEA, 8'h00);
    toDrivePoint();
    irqN = 1'b1;
    stepInstr(8'h58, 8'h00);
    waitRdyLow("WAI");
    repeat (5)
    begin
      @(negedge CLK);
      checkBit("rdyOut in WAI", rdyOut, 1'b0);
    end
    toDrivePoint();
    irqN = 1'b0;
    enterVector(statusExp[8] ? `W65_VEC_IRQ_EMU : `W65_VEC_IRQ_NATIVE, 16'h9300);
    stepInstr(8'hEA, 8'h00);
    waitRdyLow("STP");
    toDrivePoint();
    nmiN = 1'b0;
    irqN = 1'b0;
    repeat (10)
    begin
      @(negedge CLK);
      checkBit("rdyOut in STP", rdyOut, 1'b0);
    end
    resetEntry();
  endtask

  task automatic recordTrace(input logic stall);
    int cyc;
    trace.delete();
    cyc = 0;
    while (trace.size() < 40 && cyc < 400)
    begin
      @(negedge CLK);
      if (rdyOut)
        trace.push_back(addr);
      toDrivePoint();
      if (stall)
      begin
        ce    = ($urandom % 3) != 0;
        rdyIn = ($urandom % 3) != 0;
      end
      cyc++;
    end
    ce    = 1'b1;
    rdyIn = 1'b1;
    if (trace.size() < 40)
    begin
      errors++;
      $display("Only %0d active cycles seen in the stall run", trace.size());
    end
  endtask

  task automatic testStall;
    int i;
    prog = {8'h18, `W65_OP_XCE, `W65_OP_REP, 8'h30, `W65_OP_SEP, 8'h10, 8'h38, `W65_OP_XCE};
    loadMemory();
    applyReset();
    recordTrace(1'b0);
    plainAddrs = trace;
    applyReset();
    recordTrace(1'b1);
    for (i = 0; i < trace.size() && i < plainAddrs.size(); i++)
      checkAddr($sformatf("stalled addr %0d", i), trace[i], plainAddrs[i]);
  endtask

  initial
  begin
    void'($urandom(32'h1b40));
    RST_N  = 1'b0;
    ce     = 1'b1;
    rdyIn  = 1'b1;
    nmiN   = 1'b1;
    irqN   = 1'b1;
    errors = 0;
    checks = 0;
    testResetEntry();
    testEmuFlags();
    testNativeMode();
    testNmi(1'b1);
    testNmi(1'b0);
    testIrqWai();
    testStall();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  initial
  begin
    #(runBudget * 20 + 2000);
    $display("Timeout after %0d cycles, the tests did not finish", runBudget);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* w65Core.sv */
module w65Core
(
  input  logic           CLK,
  input  logic           RST_N,
  input  logic           ce,
  input  logic           rdyIn,
  input  logic           nmiN,
  input  logic           irqN,
  input  w65Pkg::dataT   dataIn,
  output w65Pkg::addrT   addr,
  output logic           vpa,
  output logic           vda,
  output logic           vpb,
  output logic           rdyOut,
  output w65Pkg::statusT status
);

  logic              en;
  logic              intReq;
  w65Pkg::busCycleE  busCycle;
  w65Pkg::dataT      opcode;
  w65Pkg::dataT      operand;
  logic              lastCycle;
  logic              takeInt;
  logic              execute;
  logic              waiStart;
  logic              stpStart;
  w65Pkg::intKindE   intKind;

  w65Sequencer i_w65Sequencer
  (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .en        (en),
    .intReq    (intReq),
    .dataIn    (dataIn),
    .busCycle  (busCycle),
    .opcode    (opcode),
    .operand   (operand),
    .lastCycle (lastCycle),
    .takeInt   (takeInt),
    .execute   (execute),
    .waiStart  (waiStart),
    .stpStart  (stpStart)
  );

  w65BusUnit i_w65BusUnit
  (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .en       (en),
    .busCycle (busCycle),
    .dataIn   (dataIn),
    .intKind  (intKind),
    .status   (status),
    .addr     (addr),
    .vpa      (vpa),
    .vda      (vda),
    .vpb      (vpb)
  );

  w65StatusReg i_w65StatusReg
  (
    .CLK     (CLK),
    .RST_N   (RST_N),
    .en      (en),
    .execute (execute),
    .opcode  (opcode),
    .operand (operand),
    .status  (status)
  );

  w65IntCtrl i_w65IntCtrl
  (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .ce        (ce),
    .rdyIn     (rdyIn),
    .nmiN      (nmiN),
    .irqN      (irqN),
    .lastCycle (lastCycle),
    .takeInt   (takeInt),
    .waiStart  (waiStart),
    .stpStart  (stpStart),
    .status    (status),
    .en        (en),
    .intReq    (intReq),
    .rdyOut    (rdyOut),
    .intKind   (intKind)
  );

endmodule

/* w65Sequencer.sv */
`include "w65_config.svh"

module w65Sequencer
(
  input  logic             CLK,
  input  logic             RST_N,
  input  logic             en,
  input  logic             intReq,
  input  w65Pkg::dataT     dataIn,
  output w65Pkg::busCycleE busCycle,
  output w65Pkg::dataT     opcode,
  output w65Pkg::dataT     operand,
  output logic             lastCycle,
  output logic             takeInt,
  output logic             execute,
  output logic             waiStart,
  output logic             stpStart
);

  w65Pkg::seqStateE state;
  w65Pkg::seqStateE nextState;
  logic             waiSeen;
  logic             hasOperand;
  logic             isFlagOp;
  logic             isModeOp;
  logic             isWai;
  logic             execCycle;

  assign hasOperand = (dataIn == `W65_OP_REP) || (dataIn == `W65_OP_SEP);  // Seen on the fetch
  assign isFlagOp   = (opcode[4:0] == 5'b11000) && (opcode[7:5] != 3'b100);  // x8 except TYA
  assign isModeOp   = (opcode == `W65_OP_REP) || (opcode == `W65_OP_SEP) ||
                      (opcode == `W65_OP_XCE);
  assign isWai      = opcode == `W65_OP_WAI;

  assign lastCycle = state == w65Pkg::seqExecute;
  assign execCycle = en && lastCycle;
  assign takeInt   = execCycle && intReq;
  assign execute   = execCycle && (isFlagOp || isModeOp);
  assign waiStart  = execCycle && isWai && !waiSeen && !intReq;
  assign stpStart  = execCycle && (opcode == `W65_OP_STP);

  always_comb
  begin
    nextState = w65Pkg::seqFetch;
    busCycle  = w65Pkg::busInternal;
    case (state)
      w65Pkg::seqFetch:
      begin
        busCycle  = w65Pkg::busOpFetch;
        nextState = hasOperand ? w65Pkg::seqOperand : w65Pkg::seqExecute;
      end
      w65Pkg::seqOperand:
      begin
        busCycle  = w65Pkg::busOperand;
        nextState = w65Pkg::seqExecute;
      end
      w65Pkg::seqExecute:
      begin
        if (intReq)
          nextState = w65Pkg::seqIntInternal;
        else if (isWai && !waiSeen)
          nextState = w65Pkg::seqExecute;  // Boundary is decided again on wake-up
        else
          nextState = w65Pkg::seqFetch;
      end
      w65Pkg::seqIntInternal:
        nextState = w65Pkg::seqVecLow;
      w65Pkg::seqVecLow:
      begin
        busCycle  = w65Pkg::busVector;
        nextState = w65Pkg::seqVecHigh;
      end
      w65Pkg::seqVecHigh:
        busCycle = w65Pkg::busVector;
      default:
        nextState = w65Pkg::seqFetch;
    endcase
  end

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      state   <= w65Pkg::seqIntInternal;  // Reset entry
      waiSeen <= 1'b0;
    end
    else if (en)
    begin
      state <= nextState;
      if (lastCycle)
        waiSeen <= waiStart;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (en && (state == w65Pkg::seqFetch))
      opcode <= dataIn;
    if (en && (state == w65Pkg::seqOperand))
      operand <= dataIn;
  end

endmodule

/* w65BusUnit.sv */
`include "w65_config.svh"

module w65BusUnit
(
  input  logic             CLK,
  input  logic             RST_N,
  input  logic             en,
  input  w65Pkg::busCycleE busCycle,
  input  w65Pkg::dataT     dataIn,
  input  w65Pkg::intKindE  intKind,
  input  w65Pkg::statusT   status,
  output w65Pkg::addrT     addr,
  output logic             vpa,
  output logic             vda,
  output logic             vpb
);

  w65Pkg::addrT pc;
  w65Pkg::addrT vector;
  logic         vecHigh;  // Second byte of the vector pair

  always_comb
  begin
    case (intKind)
      w65Pkg::intNmi:
        vector = status[8] ? `W65_VEC_NMI_EMU : `W65_VEC_NMI_NATIVE;
      w65Pkg::intIrq:
        vector = status[8] ? `W65_VEC_IRQ_EMU : `W65_VEC_IRQ_NATIVE;
      default:
        vector = `W65_VEC_RESET;
    endcase
  end

  assign addr = (busCycle == w65Pkg::busVector) ? vector + w65Pkg::addrT'(vecHigh) : pc;

  assign vpa = (busCycle == w65Pkg::busOpFetch) || (busCycle == w65Pkg::busOperand);
  assign vda = (busCycle == w65Pkg::busOpFetch) || (busCycle == w65Pkg::busVector);
  assign vpb = busCycle != w65Pkg::busVector;

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      pc      <= '0;
      vecHigh <= 1'b0;
    end
    else if (en)
    begin
      case (busCycle)
        w65Pkg::busOpFetch,
        w65Pkg::busOperand:
          pc <= pc + 16'd1;
        w65Pkg::busVector:
        begin
          if (vecHigh)
            pc[15:8] <= dataIn;
          else
            pc[7:0] <= dataIn;
          vecHigh <= !vecHigh;
        end
        default:
          pc <= pc;
      endcase
    end
  end

endmodule

/* w65StatusReg.sv */
`include "w65_config.svh"

module w65StatusReg
(
  input  logic           CLK,
  input  logic           RST_N,
  input  logic           en,
  input  logic           execute,
  input  w65Pkg::dataT   opcode,
  input  w65Pkg::dataT   operand,
  output w65Pkg::statusT status
);

  w65Pkg::dataT emuMask;  // M and X pinned while E is set

  assign emuMask = {2'b00, status[8], status[8], 4'b0000};

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
      status <= `W65_STATUS_RESET;
    else if (en && execute)
    begin
      case (opcode)
        `W65_OP_REP:
          status[7:0] <= (status[7:0] & ~operand) | emuMask;
        `W65_OP_SEP:
          status[7:0] <= status[7:0] | operand;
        `W65_OP_XCE:
        begin
          status[8] <= status[0];
          status[0] <= status[8];
          if (status[0])
          begin
            status[5] <= 1'b1;  // Entering emulation
            status[4] <= 1'b1;
          end
        end
        default:
        begin
          // Flag opcodes take the new value from bit 5
          case (opcode[7:6])
            2'b00:
              status[0] <= opcode[5];
            2'b01:
              status[2] <= opcode[5];
            2'b10:
              status[6] <= 1'b0;  // CLV only
            default:
              status[3] <= opcode[5];
          endcase
        end
      endcase
    end
  end

endmodule

/* w65IntCtrl.sv */
module w65IntCtrl
(
  input  logic            CLK,
  input  logic            RST_N,
  input  logic            ce,
  input  logic            rdyIn,
  input  logic            nmiN,
  input  logic            irqN,
  input  logic            lastCycle,
  input  logic            takeInt,
  input  logic            waiStart,
  input  logic            stpStart,
  input  w65Pkg::statusT  status,
  output logic            en,
  output logic            intReq,
  output logic            rdyOut,
  output w65Pkg::intKindE intKind
);

  logic sample;
  logic nmiMeta;
  logic nmiOld;
  logic nmiEdge;
  logic nmiPending;
  logic waiting;
  logic stopped;

  assign sample  = rdyIn && ce;
  assign nmiEdge = nmiOld && !nmiMeta;  // Falling edge
  assign en      = sample && !waiting && !stopped;
  assign rdyOut  = en;
  assign intReq  = nmiPending || (!irqN && !status[2]);  // IRQ masked by I

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      nmiMeta    <= 1'b1;
      nmiOld     <= 1'b1;
      nmiPending <= 1'b0;
    end
    else if (sample)
    begin
      nmiMeta <= nmiN;
      nmiOld  <= nmiMeta;
      if (nmiEdge)
        nmiPending <= 1'b1;
      else if (en && lastCycle)
        nmiPending <= 1'b0;  // Taken at this boundary
    end
  end

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      intKind <= w65Pkg::intReset;
      waiting <= 1'b0;
      stopped <= 1'b0;
    end
    else
    begin
      if (takeInt)
        intKind <= nmiPending ? w65Pkg::intNmi : w65Pkg::intIrq;
      if (waiStart)
        waiting <= 1'b1;
      else if (waiting && sample && (nmiPending || !irqN))
        waiting <= 1'b0;  // Wakes even with I set
      if (stpStart)
        stopped <= 1'b1;
    end
  end

endmodule

/* w65Pkg.sv */
package w65Pkg;

  typedef logic [15:0] addrT;
  typedef logic [7:0]  dataT;

  // E in bit 8, then N V M X D I Z C
  typedef logic [8:0]  statusT;

  typedef enum logic [1:0]
  {
    busOpFetch,
    busOperand,
    busInternal,
    busVector
  } busCycleE;

  typedef enum logic [2:0]
  {
    seqFetch,
    seqOperand,
    seqExecute,
    seqIntInternal,
    seqVecLow,
    seqVecHigh
  } seqStateE;

  typedef enum logic [1:0]
  {
    intReset,
    intNmi,
    intIrq
  } intKindE;

endpackage

/* w65_config.svh */
`ifndef W65_CONFIG_SVH
`define W65_CONFIG_SVH

// E, M, X and I set
`define W65_STATUS_RESET   9'h134

// Bank 0 vectors
`define W65_VEC_RESET      16'hFFFC
`define W65_VEC_NMI_NATIVE 16'hFFEA
`define W65_VEC_NMI_EMU    16'hFFFA
`define W65_VEC_IRQ_NATIVE 16'hFFEE
`define W65_VEC_IRQ_EMU    16'hFFFE

`define W65_OP_REP         8'hC2
`define W65_OP_SEP         8'hE2
`define W65_OP_XCE         8'hFB
`define W65_OP_WAI         8'hCB
`define W65_OP_STP         8'hDB

`endif
